//--- Bender.yml
package:
  name: nibble_rv

sources:
  - hw/nrv_pkg.sv
  - hw/nrv_regfile.sv
  - hw/nrv_alu_nibble.sv
  - hw/nrv_addr_unit.sv
  - hw/nrv_control.sv
  - hw/nrv_top.sv
  - target: test
    files:
      - tests/nrv_clk_gen.sv
      - tests/nrv_properties.sv
      - tests/nrv_tb.sv

//--- hw/nrv_addr_unit.sv
`default_nettype none

module nrv_addr_unit import nrv_pkg::*; (
    input  wire addr_req_t req,
    output addr_res_t      res
);

    logic [xlen-1:0] pc_inc;  // sequential pc
    logic [xlen-1:0] pc_rel;  // beq, jal, auipc
    logic [xlen-1:0] rs1_rel; // jalr, lw, sw

    // three full-width adders, all in parallel with the serial alu
    assign pc_inc  = req.pc + xlen'(4);
    assign pc_rel  = req.pc + req.imm;
    assign rs1_rel = req.rs1 + req.imm;

    always_comb begin
        res.pc_plus4    = pc_inc;
        res.br_target   = pc_rel;
        res.jalr_target = {rs1_rel[xlen-1:1], 1'b0}; // lsb cleared per spec
        res.mem_addr    = rs1_rel;                   // word aligned by software
    end

endmodule

`default_nettype wire

//--- hw/nrv_alu_nibble.sv
`default_nettype none

module nrv_alu_nibble import nrv_pkg::*; (
    input  wire logic         clk,
    input  wire logic         arst_n,
    input  wire alu_req_t     req,
    output logic [xlen-1:0]   result,
    output logic              done
);

    logic [xlen-1:0]      a_q;     // operand a, shifted right each step
    logic [xlen-1:0]      b_q;     // operand b, pre-inverted for sub
    logic [xlen-1:0]      res_q;   // result nibbles shift in from the top
    alu_op_e              op_q;
    logic                 carry_q; // carry between nibbles
    logic                 busy_q;
    logic [nib_cnt_w-1:0] cnt_q;   // current nibble index
    logic [4:0]           sum;     // nibble add with carry out
    logic [3:0]           nib;     // this cycle's result nibble

    assign sum = {1'b0, a_q[3:0]} + {1'b0, b_q[3:0]} + {4'b0000, carry_q};

    always_comb begin
        case (op_q)
            alu_and: nib = a_q[3:0] & b_q[3:0];
            alu_or:  nib = a_q[3:0] | b_q[3:0];
            alu_xor: nib = a_q[3:0] ^ b_q[3:0];
            default: nib = sum[3:0]; // add and sub share the adder
        endcase
    end

    // last nibble joins the shifted ones directly, so done lands on step 8
    assign result = {nib, res_q[xlen-1:4]};
    assign done   = busy_q && (cnt_q == nib_cnt_w'(nibbles - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q  <= 1'b0;
            cnt_q   <= '0;
            carry_q <= 1'b0;
        end else if (req.start) begin
            busy_q  <= 1'b1;
            cnt_q   <= '0;
            carry_q <= (req.op == alu_sub); // +1 for two's complement
        end else if (busy_q) begin
            carry_q <= sum[4]; // logic ops never read it
            cnt_q   <= cnt_q + 1'b1;
            if (done) begin
                busy_q <= 1'b0;
            end
        end
    end

    // operand and result datapath
    always_ff @(posedge clk) begin
        if (req.start) begin
            a_q  <= req.a;
            b_q  <= (req.op == alu_sub) ? ~req.b : req.b;
            op_q <= req.op;
        end else if (busy_q) begin
            a_q   <= a_q >> 4;
            b_q   <= b_q >> 4;
            res_q <= {nib, res_q[xlen-1:4]};
        end
    end

endmodule

`default_nettype wire

//--- hw/nrv_control.sv
`default_nettype none

module nrv_control import nrv_pkg::*; (
    input  wire logic            clk,
    input  wire logic            arst_n,
    output apb_req_t             apb_req,
    input  wire apb_rsp_t        apb_rsp,
    output logic                 halted,
    output logic                 illegal,
    output logic      [4:0]      rs1_addr,
    output logic      [4:0]      rs2_addr,
    input  wire logic [xlen-1:0] rs1_data,
    input  wire logic [xlen-1:0] rs2_data,
    output logic                 we,
    output logic      [4:0]      rd_addr,
    output logic      [xlen-1:0] rd_data,
    output alu_req_t             alu_req,
    input  wire logic [xlen-1:0] alu_result,
    input  wire logic            alu_done,
    output addr_req_t            addr_req,
    input  wire addr_res_t       addr_res
);

    ctrl_state_e     state_q;
    apb_req_t        apb_q;      // registered apb master outputs
    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] ir_q;       // instruction register
    logic [xlen-1:0] alu_q;      // alu result at done
    logic [xlen-1:0] load_q;     // lw data
    addr_res_t       addr_q;     // address unit sampled in execute
    logic            br_taken_q; // rs1 == rs2
    logic            alu_run_q;  // alu started, waiting for done
    logic            halted_q;
    logic            illegal_q;
    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] next_pc;
    alu_op_e         alu_sel;
    logic            legal;
    logic            use_alu;    // 9 cycle execute
    logic            writes_rd;
    logic            xfer_done;  // apb access phase completes

    assign opcode   = opcode_e'(ir_q[6:0]);
    assign funct3   = ir_q[14:12];
    assign funct7   = ir_q[31:25];
    assign rs1_addr = ir_q[19:15];
    assign rs2_addr = ir_q[24:20];
    assign rd_addr  = ir_q[11:7];

    always_comb begin
        imm = {{20{ir_q[31]}}, ir_q[31:20]}; // i-type
        case (opcode)
            store:      imm = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
            branch:     imm = {{19{ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
            lui, auipc: imm = {ir_q[31:12], 12'h000};
            jal:        imm = {{11{ir_q[31]}}, ir_q[31], ir_q[19:12], ir_q[20], ir_q[30:21], 1'b0};
            default: ;
        endcase
    end

    // legality and alu op select
    always_comb begin
        legal   = 1'b0;
        alu_sel = alu_add; // addi, lw, sw address add
        case (opcode)
            op_imm: legal = (funct3 == 3'b000);
            op: begin
                legal = (funct7 == 7'h00) || (funct7 == 7'h20 && funct3 == 3'b000);
                case (funct3)
                    3'b000:  alu_sel = funct7[5] ? alu_sub : alu_add;
                    3'b100:  alu_sel = alu_xor;
                    3'b110:  alu_sel = alu_or;
                    3'b111:  alu_sel = alu_and;
                    default: legal = 1'b0;
                endcase
            end
            load, store:     legal = (funct3 == 3'b010); // word only
            lui, auipc, jal: legal = 1'b1;
            jalr, branch:    legal = (funct3 == 3'b000);
            system:          legal = (ir_q == 32'h0010_0073); // ebreak
            default:         legal = 1'b0;
        endcase
    end

    assign use_alu   = (opcode == op_imm) || (opcode == op) || (opcode == load) ||
                       (opcode == store);
    assign writes_rd = (opcode != store) && (opcode != branch) && (opcode != system);
    assign xfer_done = apb_q.psel && apb_q.penable && apb_rsp.pready;

    assign alu_req.op    = alu_sel;
    assign alu_req.a     = rs1_data;
    assign alu_req.b     = (opcode == op) ? rs2_data : imm;
    assign alu_req.start = (state_q == execute) && use_alu && !alu_run_q;
    assign addr_req      = '{pc: pc_q, rs1: rs1_data, imm: imm};

    always_comb begin
        case (opcode)
            load:      rd_data = load_q;
            lui:       rd_data = imm;
            auipc:     rd_data = addr_q.br_target;
            jal, jalr: rd_data = addr_q.pc_plus4; // link
            default:   rd_data = alu_q;
        endcase
    end

    always_comb begin
        case (opcode)
            jal:     next_pc = addr_q.br_target;
            jalr:    next_pc = addr_q.jalr_target;
            branch:  next_pc = br_taken_q ? addr_q.br_target : addr_q.pc_plus4;
            default: next_pc = addr_q.pc_plus4;
        endcase
    end

    assign we      = (state_q == writeback) && writes_rd;
    assign apb_req = apb_q;
    assign halted  = halted_q;
    assign illegal = illegal_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= fetch;
            pc_q      <= start_addr;
            apb_q     <= '0;
            alu_run_q <= 1'b0;
            halted_q  <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            if (apb_q.psel && !apb_q.penable) begin
                apb_q.penable <= 1'b1; // setup -> access
            end
            if (xfer_done) begin
                apb_q.psel    <= 1'b0;
                apb_q.penable <= 1'b0;
            end
            case (state_q)
                fetch: begin
                    if (!apb_q.psel) begin // only right after reset
                        apb_q.psel   <= 1'b1;
                        apb_q.paddr  <= pc_q;
                        apb_q.pwrite <= 1'b0;
                    end else if (xfer_done) begin
                        state_q <= apb_rsp.pslverr ? halt : decode;
                        halted_q  <= apb_rsp.pslverr;
                        illegal_q <= apb_rsp.pslverr;
                    end
                end
                decode: begin
                    if (!legal || opcode == system) begin
                        state_q   <= halt;
                        halted_q  <= 1'b1;
                        illegal_q <= !legal; // ebreak halts cleanly
                    end else begin
                        state_q <= execute;
                    end
                end
                execute: begin
                    if (!use_alu) begin
                        state_q <= writeback;
                    end else if (alu_req.start) begin
                        alu_run_q <= 1'b1;
                    end else if (alu_done) begin
                        alu_run_q <= 1'b0;
                        if (opcode == load || opcode == store) begin
                            apb_q.psel   <= 1'b1; // data setup phase
                            apb_q.paddr  <= addr_res.mem_addr;
                            apb_q.pwrite <= (opcode == store);
                            apb_q.pwdata <= rs2_data;
                            state_q      <= mem_access;
                        end else begin
                            state_q <= writeback;
                        end
                    end
                end
                mem_access: begin
                    if (xfer_done) begin
                        state_q   <= apb_rsp.pslverr ? halt : writeback;
                        halted_q  <= apb_rsp.pslverr;
                        illegal_q <= apb_rsp.pslverr;
                    end
                end
                writeback: begin
                    pc_q         <= next_pc;
                    apb_q.psel   <= 1'b1; // next fetch setup
                    apb_q.paddr  <= next_pc;
                    apb_q.pwrite <= 1'b0;
                    state_q      <= fetch;
                end
                default: state_q <= halt;
            endcase
        end
    end

    // instruction and data payload capture
    always_ff @(posedge clk) begin
        if (state_q == fetch && xfer_done) begin
            ir_q <= apb_rsp.prdata;
        end
        if (state_q == mem_access && xfer_done) begin
            load_q <= apb_rsp.prdata;
        end
        if (state_q == execute) begin
            addr_q     <= addr_res;
            br_taken_q <= (rs1_data == rs2_data);
        end
        if (alu_done) begin
            alu_q <= alu_result;
        end
    end

endmodule

`default_nettype wire

//--- hw/nrv_pkg.sv
`default_nettype none

package nrv_pkg;

    localparam int xlen      = 32;              // data width
    localparam int nibbles   = xlen / 4;        // serial alu steps per op
    localparam int nib_cnt_w = $clog2(nibbles); // nibble counter width

    localparam logic [xlen-1:0] start_addr = 32'h00ff_0004; // reset pc

    // rv32i major opcodes, only the implemented ones
    typedef enum logic [6:0] {
        op_imm = 7'b001_0011, // addi
        op     = 7'b011_0011, // add sub and or xor
        load   = 7'b000_0011, // lw
        store  = 7'b010_0011, // sw
        lui    = 7'b011_0111,
        auipc  = 7'b001_0111,
        jal    = 7'b110_1111,
        jalr   = 7'b110_0111,
        branch = 7'b110_0011, // beq only
        system = 7'b111_0011  // ebreak only
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub, // b inverted, carry-in set
        alu_and,
        alu_or,
        alu_xor
    } alu_op_e;

    typedef enum logic [2:0] {
        fetch,
        decode,
        execute,
        mem_access, // lw / sw data phase
        writeback,
        halt        // sticky until reset
    } ctrl_state_e;

    // apb3 master -> slave, 67 bits
    typedef struct packed {
        logic [xlen-1:0] paddr;
        logic            pwrite;
        logic [xlen-1:0] pwdata;
        logic            psel;
        logic            penable;
    } apb_req_t;

    // apb3 slave -> master, 34 bits
    typedef struct packed {
        logic [xlen-1:0] prdata;
        logic            pready;
        logic            pslverr;
    } apb_rsp_t;

    typedef struct packed {
        alu_op_e         op;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic            start; // one cycle pulse
    } alu_req_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1;
        logic [xlen-1:0] imm;
    } addr_req_t;

    typedef struct packed {
        logic [xlen-1:0] pc_plus4;
        logic [xlen-1:0] br_target;   // pc + imm
        logic [xlen-1:0] jalr_target; // (rs1 + imm) & ~1
        logic [xlen-1:0] mem_addr;    // rs1 + imm
    } addr_res_t;

endpackage

`default_nettype wire

//--- hw/nrv_regfile.sv
`default_nettype none

module nrv_regfile import nrv_pkg::*; (
    input  wire logic            clk,
    input  wire logic            arst_n,
    input  wire logic [4:0]      rs1_addr,
    input  wire logic [4:0]      rs2_addr,
    output logic      [xlen-1:0] rs1_data,
    output logic      [xlen-1:0] rs2_data,
    input  wire logic            we,
    input  wire logic [4:0]      rd_addr,
    input  wire logic [xlen-1:0] rd_data
);

    logic [xlen-1:0] regs_q [1:31]; // x0 not stored

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we && (rd_addr != 5'd0)) begin // writes to x0 dropped
            regs_q[rd_addr] <= rd_data;
        end
    end

    // combinational reads, x0 hardwired
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs_q[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs_q[rs2_addr];

endmodule

`default_nettype wire

//--- hw/nrv_top.sv
`default_nettype none

module nrv_top import nrv_pkg::*; (
    input  wire logic     clk,
    input  wire logic     arst_n,
    output apb_req_t      apb_req,
    input  wire apb_rsp_t apb_rsp,
    output logic          halted,
    output logic          illegal
);

    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [4:0]      rd_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] rd_data;
    logic            we;
    alu_req_t        alu_req;
    logic [xlen-1:0] alu_result;
    logic            alu_done;
    addr_req_t       addr_req;
    addr_res_t       addr_res;

    nrv_control u_control (
        .clk        (clk),
        .arst_n     (arst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .halted     (halted),
        .illegal    (illegal),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .we         (we),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .alu_req    (alu_req),
        .alu_result (alu_result),
        .alu_done   (alu_done),
        .addr_req   (addr_req),
        .addr_res   (addr_res)
    );

    nrv_regfile u_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (we),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    nrv_alu_nibble u_alu (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (alu_req),
        .result (alu_result),
        .done   (alu_done)
    );

    nrv_addr_unit u_addr (
        .req (addr_req),
        .res (addr_res)
    );

endmodule

`default_nettype wire

//--- nibble_rv.f
hw/nrv_pkg.sv
hw/nrv_regfile.sv
hw/nrv_alu_nibble.sv
hw/nrv_addr_unit.sv
hw/nrv_control.sv
hw/nrv_top.sv
tests/nrv_clk_gen.sv
tests/nrv_properties.sv
tests/nrv_tb.sv

//--- tests/nrv_clk_gen.sv
`default_nettype none

module nrv_clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk; // period 100

endmodule

`default_nettype wire

//--- tests/nrv_properties.sv
`default_nettype none

module nrv_properties import nrv_pkg::*; (
    input wire logic     clk,
    input wire logic     arst_n,
    input wire apb_req_t apb_req,
    input wire apb_rsp_t apb_rsp,
    input wire logic     halted
);

    int unsigned fail_cnt = 0; // failed assertions so far

    // access phase only inside a selected transfer
    penable_needs_psel: assert property (
        @(posedge clk) disable iff (!arst_n) apb_req.penable |-> apb_req.psel
    ) else begin
        fail_cnt++;
        $error("apb penable high without psel");
    end

    // request frozen until the slave answers
    req_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        (apb_req.psel && !apb_rsp.pready) |=>
            ($stable(apb_req.paddr) && $stable(apb_req.pwrite) &&
             $stable(apb_req.pwdata) && apb_req.psel)
    ) else begin
        fail_cnt++;
        $error("apb request changed while waiting for pready");
    end

    quiet_in_reset: assert property (
        @(posedge clk) !arst_n |-> (!apb_req.psel && !apb_req.penable && !halted)
    ) else begin
        fail_cnt++;
        $error("apb or halted active during reset");
    end

endmodule

bind nrv_top nrv_properties u_props (
    .clk     (clk),
    .arst_n  (arst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .halted  (halted)
);

`default_nettype wire

//--- tests/nrv_tb.sv
`default_nettype none

module nrv_tb import nrv_pkg::*; ();

    localparam int prog_instrs     = 71;                  // all programs together
    localparam int watchdog_cycles = prog_instrs * 30 * 4;
    localparam int run_limit       = 2000;                // cycles per program
    localparam logic [31:0] ebreak = 32'h0010_0073;

    logic            clk;
    logic            arst_n;
    apb_req_t        apb_req;
    apb_rsp_t        apb_rsp;
    logic            halted;
    logic            illegal;

    logic [31:0]     mem [0:1023];   // word addressed by paddr[11:2]
    logic [31:0]     rng_state;
    logic            rand_waits;     // random 0..3 wait states
    logic            err_en;         // pslverr injection
    logic [31:0]     err_addr;
    int unsigned     wait_cnt;
    int unsigned     wait_draw;
    int unsigned     xfers;          // setup phases seen
    int unsigned     errors;
    logic [31:0]     wr_addr_q [$];  // completed writes
    logic [31:0]     wr_data_q [$];
    logic [31:0]     rd_addr_q [$];  // completed reads, fetches mostly
    logic [31:0]     exp_addr_q [$];
    logic [31:0]     exp_data_q [$];

    nrv_clk_gen u_clk (
        .clk (clk)
    );

    nrv_top u_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .halted  (halted),
        .illegal (illegal)
    );

    function automatic logic [31:0] xorshift();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    function automatic int unsigned word_index(logic [31:0] addr);
        return int'(addr[11:2]);
    endfunction

    // rv32i instruction formats
    function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'(op)};
    endfunction

    function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'(store)};
    endfunction

    function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'(branch)};
    endfunction

    function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'(jal)};
    endfunction

    function automatic logic [31:0] addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return i_type(imm, rs1, 3'b000, rd, 7'(op_imm));
    endfunction

    // fetch that followed the first fetch from addr
    function automatic logic [31:0] next_fetch(logic [31:0] addr);
        for (int i = 0; i + 1 < rd_addr_q.size(); i++) begin
            if (rd_addr_q[i] == addr) begin
                return rd_addr_q[i+1];
            end
        end
        return 32'hdead_beef; // never fetched
    endfunction

    // apb slave memory, rsp driven on the rising edge
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            apb_rsp  <= '0;
            wait_cnt <= 0;
        end else if (apb_rsp.pready) begin // transfer completes on this edge
            apb_rsp.pready  <= 1'b0;
            apb_rsp.pslverr <= 1'b0;
            if (apb_req.pwrite) begin
                mem[word_index(apb_req.paddr)] <= apb_req.pwdata;
                wr_addr_q.push_back(apb_req.paddr);
                wr_data_q.push_back(apb_req.pwdata);
            end else begin
                rd_addr_q.push_back(apb_req.paddr);
            end
        end else if (apb_req.psel && !apb_req.penable) begin
            xfers++;
            wait_draw = rand_waits ? (xorshift() % 4) : 0;
            if (wait_draw == 0) begin
                apb_rsp.pready  <= 1'b1;
                apb_rsp.prdata  <= mem[word_index(apb_req.paddr)];
                apb_rsp.pslverr <= err_en && (apb_req.paddr == err_addr);
            end else begin
                wait_cnt <= wait_draw - 1;
            end
        end else if (apb_req.psel && apb_req.penable) begin
            if (wait_cnt == 0) begin
                apb_rsp.pready  <= 1'b1;
                apb_rsp.prdata  <= mem[word_index(apb_req.paddr)];
                apb_rsp.pslverr <= err_en && (apb_req.paddr == err_addr);
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    task automatic check_eq(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic begin_reset(logic waits);
        @(posedge clk);
        arst_n <= 1'b0;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = {i[15:0], ~i[15:0]}; // background, differs per word
        end
        wr_addr_q.delete();
        wr_data_q.delete();
        rd_addr_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
        rand_waits = waits;
        err_en     = 1'b0;
        err_addr   = '0;
    endtask

    task automatic end_reset();
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    task automatic put_instr(int idx, logic [31:0] word);
        mem[word_index(start_addr) + idx] = word;
    endtask

    task automatic expect_write(logic [31:0] addr, logic [31:0] data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    task automatic wait_halted(string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!halted && n < run_limit) begin
            @(negedge clk);
            n++;
        end
        if (!halted) begin
            errors++;
            $display("%s: core did not halt within %0d cycles", name, run_limit);
        end
    endtask

    task automatic compare_writes(string name);
        int n;
        n = (exp_addr_q.size() < wr_addr_q.size()) ? exp_addr_q.size() : wr_addr_q.size();
        check_eq({name, " write count"}, exp_addr_q.size(), wr_addr_q.size());
        for (int i = 0; i < n; i++) begin
            check_eq($sformatf("%s write %0d addr", name, i), exp_addr_q[i], wr_addr_q[i]);
            check_eq($sformatf("%s write %0d data", name, i), exp_data_q[i], wr_data_q[i]);
        end
    endtask

    task automatic alu_ops(string name, logic waits);
        logic [31:0] a;
        logic [31:0] b;
        a = ({20'h12345, 12'h000}) + 32'h0000_0678;
        b = 32'hffff_ffff - 32'd99; // -100
        begin_reset(waits);
        put_instr(0, u_type(20'h12345, 5'd1, 7'(lui)));
        put_instr(1, addi(5'd1, 5'd1, 12'h678));
        put_instr(2, addi(5'd2, 5'd0, 12'(-100)));
        put_instr(3, r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3)); // add
        put_instr(4, r_type(7'h20, 5'd1, 5'd2, 3'b000, 5'd4)); // sub x2 - x1
        put_instr(5, r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5)); // and
        put_instr(6, r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6)); // or
        put_instr(7, r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd7)); // xor
        put_instr(8, addi(5'd8, 5'd2, 12'(-5)));
        for (int k = 0; k < 7; k++) begin
            put_instr(9 + k, s_type(12'(32'h100 + 4 * k), 5'(2 + k), 5'd0));
        end
        put_instr(16, ebreak);
        expect_write(32'h100, b);
        expect_write(32'h104, a + b);
        expect_write(32'h108, b - a);
        expect_write(32'h10c, a & b);
        expect_write(32'h110, a | b);
        expect_write(32'h114, a ^ b);
        expect_write(32'h118, b - 32'd5);
        end_reset();
        wait_halted(name);
        compare_writes(name);
        check_eq({name, " illegal"}, 32'd0, 32'(illegal));
    endtask

    task automatic load_store();
        logic [31:0] seed_word;
        begin_reset(1'b0);
        seed_word = xorshift();
        mem[word_index(32'h108)] = seed_word;
        put_instr(0, addi(5'd1, 5'd0, 12'h100));
        put_instr(1, i_type(12'd8, 5'd1, 3'b010, 5'd2, 7'(load)));    // lw x2, 8(x1)
        put_instr(2, addi(5'd3, 5'd0, 12'h110));
        put_instr(3, i_type(12'(-8), 5'd3, 3'b010, 5'd4, 7'(load))); // lw x4, -8(x3)
        put_instr(4, s_type(12'h200, 5'd2, 5'd0));
        put_instr(5, s_type(12'h204, 5'd4, 5'd0));
        put_instr(6, ebreak);
        expect_write(32'h200, seed_word);
        expect_write(32'h204, seed_word);
        end_reset();
        wait_halted("load_store");
        compare_writes("load_store");
    endtask

    task automatic upper_jumps();
        logic [31:0] s;
        s = start_addr;
        begin_reset(1'b0);
        put_instr(0, u_type(20'habcde, 5'd1, 7'(lui)));
        put_instr(1, u_type(20'h00001, 5'd2, 7'(auipc)));
        put_instr(2, j_type(21'd12, 5'd3));                 // to index 5
        put_instr(3, addi(5'd9, 5'd0, 12'd1));              // skipped
        put_instr(4, s_type(12'h2f0, 5'd9, 5'd0));          // skipped
        put_instr(5, s_type(12'h300, 5'd1, 5'd0));
        put_instr(6, s_type(12'h304, 5'd2, 5'd0));
        put_instr(7, s_type(12'h308, 5'd3, 5'd0));
        put_instr(8, u_type(20'h00000, 5'd5, 7'(auipc)));
        put_instr(9, i_type(12'd16, 5'd5, 3'b000, 5'd6, 7'(jalr))); // to index 12
        put_instr(10, addi(5'd9, 5'd0, 12'd2));             // skipped
        put_instr(11, s_type(12'h2f4, 5'd9, 5'd0));         // skipped
        put_instr(12, s_type(12'h30c, 5'd6, 5'd0));
        put_instr(13, ebreak);
        expect_write(32'h300, 32'habcd_e000);
        expect_write(32'h304, s + 32'd4 + 32'h1000);
        expect_write(32'h308, s + 32'd12);
        expect_write(32'h30c, s + 32'd40);
        end_reset();
        wait_halted("upper_jumps");
        compare_writes("upper_jumps");
        check_eq("upper_jumps jal target", s + 32'd20, next_fetch(s + 32'd8));
        check_eq("upper_jumps jalr target", s + 32'd48, next_fetch(s + 32'd36));
    endtask

    task automatic beq_paths();
        logic [31:0] s;
        s = start_addr;
        begin_reset(1'b0);
        put_instr(0, addi(5'd1, 5'd0, 12'd5));
        put_instr(1, addi(5'd2, 5'd0, 12'd5));
        put_instr(2, addi(5'd3, 5'd0, 12'd7));
        put_instr(3, b_type(13'd12, 5'd2, 5'd1));           // taken, to index 6
        put_instr(4, addi(5'd9, 5'd0, 12'h011));
        put_instr(5, s_type(12'h400, 5'd9, 5'd0));          // wrong path marker
        put_instr(6, b_type(13'd12, 5'd3, 5'd1));           // not taken
        put_instr(7, addi(5'd9, 5'd0, 12'h022));
        put_instr(8, s_type(12'h404, 5'd9, 5'd0));          // right path marker
        put_instr(9, ebreak);
        expect_write(32'h404, 32'h22);
        end_reset();
        wait_halted("beq_paths");
        compare_writes("beq_paths");
        check_eq("beq_paths taken target", s + 32'd24, next_fetch(s + 32'd12));
        check_eq("beq_paths fallthrough", s + 32'd28, next_fetch(s + 32'd24));
    endtask

    // halted state must be final and quiet on the bus
    task automatic halt_quiet(string name, logic exp_illegal);
        int unsigned seen;
        wait_halted(name);
        check_eq({name, " halted"}, 32'd1, 32'(halted));
        check_eq({name, " illegal"}, 32'(exp_illegal), 32'(illegal));
        seen = xfers;
        repeat (20) @(negedge clk);
        check_eq({name, " transfers after halt"}, seen, xfers);
        check_eq({name, " psel after halt"}, 32'd0, 32'(apb_req.psel));
    endtask

    task automatic halting();
        begin_reset(1'b0);
        put_instr(0, addi(5'd1, 5'd0, 12'd1));
        put_instr(1, ebreak);
        end_reset();
        halt_quiet("halt_ebreak", 1'b0);

        begin_reset(1'b0);
        put_instr(0, 32'hffff_ffff); // no such opcode
        end_reset();
        halt_quiet("halt_bad_opcode", 1'b1);

        begin_reset(1'b0);
        err_en   = 1'b1;
        err_addr = 32'h100;
        put_instr(0, addi(5'd1, 5'd0, 12'h100));
        put_instr(1, i_type(12'd0, 5'd1, 3'b010, 5'd2, 7'(load)));
        put_instr(2, ebreak);
        end_reset();
        halt_quiet("halt_pslverr", 1'b1);
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        arst_n     = 1'b1; // first reset pulse comes from begin_reset
        apb_rsp    = '0;
        rng_state  = 32'h3d23_e039;
        rand_waits = 1'b0;
        err_en     = 1'b0;
        err_addr   = '0;
        errors     = 0;
        xfers      = 0;
        alu_ops("alu_ops", 1'b0);
        load_store();
        upper_jumps();
        beq_paths();
        halting();
        alu_ops("alu_ops_waits", 1'b1); // same results under back-pressure
        $display("errors: %0d, assertion failures: %0d", errors, u_dut.u_props.fail_cnt);
        if (errors == 0 && u_dut.u_props.fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
